/* verilog/lane_pkg.sv */
`default_nettype none

package lane_pkg;

    ////////////////////////////////////////
    // Data and address types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [5:0]  vreg_addr_t;
    typedef logic [4:0]  mask_addr_t;
    typedef logic [3:0]  byte_en_t;

    ////////////////////////////////////////
    // Instruction field types
    ////////////////////////////////////////

    typedef logic [1:0] sew_t;
    typedef logic [1:0] elem_idx_t;
    typedef logic [2:0] alu_op_t;
    typedef logic [1:0] op2_sel_t;
    typedef logic [4:0] imm_t;

    ////////////////////////////////////////
    // Sizes and latency
    ////////////////////////////////////////

    localparam int VREG_DEPTH = 64;
    localparam int MASK_DEPTH = 32;

    // Issue to writeback, in cycles
    localparam int PIPE_DEPTH = 3;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Element width, code 3 is illegal
    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;

    // ALU opcodes, code 7 is illegal
    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_XOR  = 3'd4;
    localparam alu_op_t ALU_SEQ  = 3'd5;
    localparam alu_op_t ALU_SLTU = 3'd6;

    // Operand 2 source, code 3 is illegal
    localparam op2_sel_t OP2_VEC    = 2'd0;
    localparam op2_sel_t OP2_SCALAR = 2'd1;
    localparam op2_sel_t OP2_IMM    = 2'd2;

endpackage

`default_nettype wire

/* verilog/vec_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module vec_regfile (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Read ports
    input  lane_pkg::vreg_addr_t ra_i,
    input  lane_pkg::vreg_addr_t rb_i,
    output lane_pkg::word_t      rdata_a_o,
    output lane_pkg::word_t      rdata_b_o,

    // Write port
    input  logic                 wb_en_i,
    input  lane_pkg::vreg_addr_t wb_addr_i,
    input  lane_pkg::byte_en_t   wb_bwen_i,
    input  lane_pkg::word_t      wb_data_i
);

    lane_pkg::word_t mem [lane_pkg::VREG_DEPTH];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < lane_pkg::VREG_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wb_en_i) begin
            for (int b = 0; b < $bits(lane_pkg::byte_en_t); b++) begin
                if (wb_bwen_i[b]) begin
                    mem[wb_addr_i][b*8 +: 8] <= wb_data_i[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Sampled at the commit edge, so a same-cycle write is not seen
    always_ff @(posedge clk_i) begin
        rdata_a_o <= mem[ra_i];
        rdata_b_o <= mem[rb_i];
    end

    // Idle writeback slots from the control pipeline carry no byte enables
    a_bwen_idle : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        !wb_en_i |-> (wb_bwen_i == '0)
    ) else $error("vec_regfile: byte enables set without a write");

endmodule

`default_nettype wire

/* verilog/mask_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mask_regfile (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Read port
    input  lane_pkg::mask_addr_t raddr_i,
    output logic                 rbit_o,

    // Write port
    input  logic                 we_i,
    input  lane_pkg::mask_addr_t waddr_i,
    input  logic                 wbit_i
);

    // One bit per entry
    logic [lane_pkg::MASK_DEPTH-1:0] bits;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            bits <= '0;
        end else if (we_i) begin
            bits[waddr_i] <= wbit_i;
        end
    end

    // Old bit on a same-edge write
    always_ff @(posedge clk_i) begin
        rbit_o <= bits[raddr_i];
    end

endmodule

`default_nettype wire

/* verilog/elem_extract.sv */
`timescale 1ns/1ns
`default_nettype none

module elem_extract (
    input  logic                clk_i,
    input  logic                rst_i,
    input  lane_pkg::word_t     word_i,
    input  lane_pkg::sew_t      sew_i,
    input  lane_pkg::elem_idx_t el_i,
    output lane_pkg::word_t     elem_o
);

    lane_pkg::word_t elem_d;

    // Element select, zero-extended
    always_comb begin
        case (sew_i)
            lane_pkg::SEW_8: begin
                elem_d = lane_pkg::word_t'(word_i[{el_i, 3'b000} +: 8]);
            end
            lane_pkg::SEW_16: begin
                // Only the low index bit picks the halfword
                elem_d = lane_pkg::word_t'(word_i[{el_i[0], 4'b0000} +: 16]);
            end
            lane_pkg::SEW_32: begin
                elem_d = word_i;
            end
            default: begin
                elem_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        elem_o <= elem_d;
    end

    // Width code comes from the issued instruction one cycle back
    a_sew_legal : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        sew_i != 2'd3
    ) else $error("elem_extract: illegal element width code");

endmodule

`default_nettype wire

/* verilog/lane_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_alu (
    input  logic               clk_i,
    input  logic               rst_i,
    input  lane_pkg::alu_op_t  op_i,
    input  lane_pkg::op2_sel_t op2_sel_i,
    input  lane_pkg::word_t    a_i,
    input  lane_pkg::word_t    b_i,
    input  lane_pkg::word_t    scalar_i,
    input  lane_pkg::imm_t     imm_i,
    output lane_pkg::word_t    result_o
);

    lane_pkg::word_t op2;
    lane_pkg::word_t alu_d;

    ////////////////////////////////////////
    // Operand 2 select
    ////////////////////////////////////////

    always_comb begin
        case (op2_sel_i)
            lane_pkg::OP2_VEC:    op2 = b_i;
            lane_pkg::OP2_SCALAR: op2 = scalar_i;
            // Immediate is unsigned
            lane_pkg::OP2_IMM:    op2 = lane_pkg::word_t'(imm_i);
            default:              op2 = '0;
        endcase
    end

    ////////////////////////////////////////
    // Operation
    ////////////////////////////////////////

    always_comb begin
        case (op_i)
            lane_pkg::ALU_ADD:  alu_d = a_i + op2;
            lane_pkg::ALU_SUB:  alu_d = a_i - op2;
            lane_pkg::ALU_AND:  alu_d = a_i & op2;
            lane_pkg::ALU_OR:   alu_d = a_i | op2;
            lane_pkg::ALU_XOR:  alu_d = a_i ^ op2;
            // Compares leave their flag in bit 0
            lane_pkg::ALU_SEQ:  alu_d = lane_pkg::word_t'(a_i == op2);
            lane_pkg::ALU_SLTU: alu_d = lane_pkg::word_t'(a_i < op2);
            default:            alu_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        result_o <= alu_d;
    end

    // Both codes were issued two cycles earlier
    a_op_legal : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        op_i != 3'd7
    ) else $error("lane_alu: illegal opcode");

    a_op2_sel_legal : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        op2_sel_i != 2'd3
    ) else $error("lane_alu: illegal operand 2 source");

endmodule

`default_nettype wire

/* verilog/issue_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_pipe (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Issue
    input  logic                 issue_i,
    input  lane_pkg::alu_op_t    op_i,
    input  lane_pkg::op2_sel_t   op2_sel_i,
    input  lane_pkg::sew_t       sew_i,
    input  lane_pkg::elem_idx_t  el_a_i,
    input  lane_pkg::elem_idx_t  el_b_i,
    input  lane_pkg::word_t      scalar_i,
    input  lane_pkg::imm_t       imm_i,
    input  lane_pkg::vreg_addr_t rd_i,
    input  lane_pkg::byte_en_t   bwen_i,
    input  logic                 vm_i,
    input  lane_pkg::mask_addr_t mask_addr_i,
    input  logic                 mask_wr_i,

    // Mask bit read at issue
    input  logic                 mask_bit_i,

    // Stage 1, extraction
    output lane_pkg::sew_t       s1_sew_o,
    output lane_pkg::elem_idx_t  s1_el_a_o,
    output lane_pkg::elem_idx_t  s1_el_b_o,

    // Stage 2, ALU
    output lane_pkg::alu_op_t    s2_op_o,
    output lane_pkg::op2_sel_t   s2_op2_sel_o,
    output lane_pkg::word_t      s2_scalar_o,
    output lane_pkg::imm_t       s2_imm_o,

    // Stage 3, writeback
    output logic                 wb_en_o,
    output lane_pkg::vreg_addr_t wb_addr_o,
    output lane_pkg::byte_en_t   wb_bwen_o,
    output logic                 mask_we_o,
    output lane_pkg::mask_addr_t mask_waddr_o
);

    logic s1_valid;
    logic s2_valid;
    logic s3_valid;

    // Stage 1 fields
    lane_pkg::alu_op_t    s1_op;
    lane_pkg::op2_sel_t   s1_op2_sel;
    lane_pkg::word_t      s1_scalar;
    lane_pkg::imm_t       s1_imm;
    lane_pkg::vreg_addr_t s1_rd;
    lane_pkg::byte_en_t   s1_bwen;
    logic                 s1_vm;
    lane_pkg::mask_addr_t s1_mask_addr;
    logic                 s1_mask_wr;

    // Stage 2 fields
    lane_pkg::vreg_addr_t s2_rd;
    lane_pkg::byte_en_t   s2_bwen;
    lane_pkg::mask_addr_t s2_mask_addr;
    logic                 s2_mask_wr;

    // Stage 3 fields
    lane_pkg::vreg_addr_t s3_rd;
    lane_pkg::byte_en_t   s3_bwen;
    lane_pkg::mask_addr_t s3_mask_addr;
    logic                 s3_cmp_wr;

    ////////////////////////////////////////
    // Valids and operation codes
    ////////////////////////////////////////

    // Codes only move with a valid, so the datapath always sees legal ones
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            s3_valid     <= 1'b0;
            s1_op        <= lane_pkg::ALU_ADD;
            s1_op2_sel   <= lane_pkg::OP2_VEC;
            s1_sew_o     <= lane_pkg::SEW_8;
            s1_el_a_o    <= '0;
            s1_el_b_o    <= '0;
            s2_op_o      <= lane_pkg::ALU_ADD;
            s2_op2_sel_o <= lane_pkg::OP2_VEC;
        end else begin
            s1_valid <= issue_i;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            if (issue_i) begin
                s1_op      <= op_i;
                s1_op2_sel <= op2_sel_i;
                s1_sew_o   <= sew_i;
                s1_el_a_o  <= el_a_i;
                s1_el_b_o  <= el_b_i;
            end
            if (s1_valid) begin
                s2_op_o      <= s1_op;
                s2_op2_sel_o <= s1_op2_sel;
            end
        end
    end

    ////////////////////////////////////////
    // Payload shift
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            s1_scalar    <= scalar_i;
            s1_imm       <= imm_i;
            s1_rd        <= rd_i;
            s1_bwen      <= bwen_i;
            s1_vm        <= vm_i;
            s1_mask_addr <= mask_addr_i;
            s1_mask_wr   <= mask_wr_i;
        end
        if (s1_valid) begin
            s2_scalar_o  <= s1_scalar;
            s2_imm_o     <= s1_imm;
            s2_rd        <= s1_rd;
            // Masked-off element keeps its destination
            s2_bwen      <= (s1_vm && !mask_bit_i) ? '0 : s1_bwen;
            s2_mask_addr <= s1_mask_addr;
            s2_mask_wr   <= s1_mask_wr;
        end
        if (s2_valid) begin
            s3_rd        <= s2_rd;
            s3_bwen      <= s2_bwen;
            s3_mask_addr <= s2_mask_addr;
            s3_cmp_wr    <= s2_mask_wr && (s2_op_o == lane_pkg::ALU_SEQ ||
                                           s2_op_o == lane_pkg::ALU_SLTU);
        end
    end

    ////////////////////////////////////////
    // Writeback decision
    ////////////////////////////////////////

    always_comb begin
        wb_en_o      = s3_valid;
        wb_addr_o    = s3_rd;
        wb_bwen_o    = s3_valid ? s3_bwen : '0;
        mask_we_o    = s3_valid && s3_cmp_wr;
        mask_waddr_o = s3_mask_addr;
    end

endmodule

`default_nettype wire

/* verilog/vector_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module vector_lane (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Instruction issue
    input  logic                 issue_i,
    input  lane_pkg::alu_op_t    op_i,
    input  lane_pkg::op2_sel_t   op2_sel_i,
    input  lane_pkg::sew_t       sew_i,
    input  lane_pkg::vreg_addr_t ra_i,
    input  lane_pkg::vreg_addr_t rb_i,
    input  lane_pkg::elem_idx_t  el_a_i,
    input  lane_pkg::elem_idx_t  el_b_i,
    input  lane_pkg::word_t      scalar_i,
    input  lane_pkg::imm_t       imm_i,
    input  lane_pkg::vreg_addr_t rd_i,
    input  lane_pkg::byte_en_t   bwen_i,
    input  logic                 vm_i,
    input  lane_pkg::mask_addr_t mask_addr_i,
    input  logic                 mask_wr_i,

    // Result
    output lane_pkg::word_t      result_o,
    output logic                 result_valid_o
);

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////

    lane_pkg::word_t      rdata_a;
    lane_pkg::word_t      rdata_b;
    logic                 mask_bit;
    lane_pkg::sew_t       s1_sew;
    lane_pkg::elem_idx_t  s1_el_a;
    lane_pkg::elem_idx_t  s1_el_b;
    lane_pkg::word_t      elem_a;
    lane_pkg::word_t      elem_b;
    lane_pkg::alu_op_t    s2_op;
    lane_pkg::op2_sel_t   s2_op2_sel;
    lane_pkg::word_t      s2_scalar;
    lane_pkg::imm_t       s2_imm;
    lane_pkg::word_t      alu_result;
    logic                 wb_en;
    lane_pkg::vreg_addr_t wb_addr;
    lane_pkg::byte_en_t   wb_bwen;
    logic                 mask_we;
    lane_pkg::mask_addr_t mask_waddr;

    assign result_o       = alu_result;
    assign result_valid_o = wb_en;

    // Register files, read at issue and written at stage 3
    vec_regfile u_vrf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ra_i      (ra_i),
        .rb_i      (rb_i),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wb_en_i   (wb_en),
        .wb_addr_i (wb_addr),
        .wb_bwen_i (wb_bwen),
        .wb_data_i (alu_result)
    );

    mask_regfile u_vmrf (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .raddr_i (mask_addr_i),
        .rbit_o  (mask_bit),
        .we_i    (mask_we),
        .waddr_i (mask_waddr),
        .wbit_i  (alu_result[0])
    );

    // Stage 1 extraction
    elem_extract u_ext_a (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .word_i (rdata_a),
        .sew_i  (s1_sew),
        .el_i   (s1_el_a),
        .elem_o (elem_a)
    );

    elem_extract u_ext_b (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .word_i (rdata_b),
        .sew_i  (s1_sew),
        .el_i   (s1_el_b),
        .elem_o (elem_b)
    );

    // Stage 2 ALU
    lane_alu u_alu (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .op_i      (s2_op),
        .op2_sel_i (s2_op2_sel),
        .a_i       (elem_a),
        .b_i       (elem_b),
        .scalar_i  (s2_scalar),
        .imm_i     (s2_imm),
        .result_o  (alu_result)
    );

    issue_pipe u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .issue_i      (issue_i),
        .op_i         (op_i),
        .op2_sel_i    (op2_sel_i),
        .sew_i        (sew_i),
        .el_a_i       (el_a_i),
        .el_b_i       (el_b_i),
        .scalar_i     (scalar_i),
        .imm_i        (imm_i),
        .rd_i         (rd_i),
        .bwen_i       (bwen_i),
        .vm_i         (vm_i),
        .mask_addr_i  (mask_addr_i),
        .mask_wr_i    (mask_wr_i),
        .mask_bit_i   (mask_bit),
        .s1_sew_o     (s1_sew),
        .s1_el_a_o    (s1_el_a),
        .s1_el_b_o    (s1_el_b),
        .s2_op_o      (s2_op),
        .s2_op2_sel_o (s2_op2_sel),
        .s2_scalar_o  (s2_scalar),
        .s2_imm_o     (s2_imm),
        .wb_en_o      (wb_en),
        .wb_addr_o    (wb_addr),
        .wb_bwen_o    (wb_bwen),
        .mask_we_o    (mask_we),
        .mask_waddr_o (mask_waddr)
    );

endmodule

`default_nettype wire

/* verification/tb_vector_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vector_lane;

    logic                 clk_i;
    logic                 rst_i;
    logic                 issue_i;
    lane_pkg::alu_op_t    op_i;
    lane_pkg::op2_sel_t   op2_sel_i;
    lane_pkg::sew_t       sew_i;
    lane_pkg::vreg_addr_t ra_i;
    lane_pkg::vreg_addr_t rb_i;
    lane_pkg::elem_idx_t  el_a_i;
    lane_pkg::elem_idx_t  el_b_i;
    lane_pkg::word_t      scalar_i;
    lane_pkg::imm_t       imm_i;
    lane_pkg::vreg_addr_t rd_i;
    lane_pkg::byte_en_t   bwen_i;
    logic                 vm_i;
    lane_pkg::mask_addr_t mask_addr_i;
    logic                 mask_wr_i;
    lane_pkg::word_t      result_o;
    logic                 result_valid_o;

    // Reference register files
    lane_pkg::word_t model_vreg [lane_pkg::VREG_DEPTH];
    logic            model_mask [lane_pkg::MASK_DEPTH];

    // Writebacks waiting for their commit edge
    int                   commit_edge_q[$];
    lane_pkg::vreg_addr_t commit_rd_q[$];
    lane_pkg::byte_en_t   commit_bwen_q[$];
    lane_pkg::word_t      commit_data_q[$];
    logic                 commit_mwe_q[$];
    lane_pkg::mask_addr_t commit_maddr_q[$];

    // Results due on result_o
    int              exp_edge_q[$];
    lane_pkg::word_t exp_data_q[$];
    string           exp_name_q[$];

    int    edge_cnt;
    int    error_cnt;
    int    check_cnt;
    string test_name;

    // Mask entry shared by a compare and the masked write after it
    lane_pkg::mask_addr_t gate_addr;

    vector_lane dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Hard stop in case the sequence never completes
    initial begin
        #100000;
        $display("Simulation limit reached before the test sequence finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic lane_pkg::word_t extract_model(lane_pkg::word_t w, lane_pkg::sew_t sew,
                                                      lane_pkg::elem_idx_t el);
        case (sew)
            lane_pkg::SEW_8:  return (w >> (8 * int'(el))) & 32'h0000_00ff;
            lane_pkg::SEW_16: return (w >> (16 * int'(el[0]))) & 32'h0000_ffff;
            lane_pkg::SEW_32: return w;
            default:          return '0;
        endcase
    endfunction

    function automatic lane_pkg::word_t alu_model(lane_pkg::alu_op_t op, lane_pkg::word_t a,
                                                  lane_pkg::word_t b);
        case (op)
            lane_pkg::ALU_ADD:  return a + b;
            lane_pkg::ALU_SUB:  return a + ~b + 32'd1;
            lane_pkg::ALU_AND:  return a & b;
            lane_pkg::ALU_OR:   return a | b;
            lane_pkg::ALU_XOR:  return a ^ b;
            lane_pkg::ALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
            lane_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:            return '0;
        endcase
    endfunction

    // Reads happen at the issue edge, before that edge's commit
    task automatic model_issue();
        lane_pkg::word_t a;
        lane_pkg::word_t b;
        lane_pkg::word_t res;
        logic            keep;
        a = extract_model(model_vreg[ra_i], sew_i, el_a_i);
        case (op2_sel_i)
            lane_pkg::OP2_SCALAR: b = scalar_i;
            lane_pkg::OP2_IMM:    b = {27'd0, imm_i};
            default:              b = extract_model(model_vreg[rb_i], sew_i, el_b_i);
        endcase
        res = alu_model(op_i, a, b);
        keep = !vm_i || model_mask[mask_addr_i];
        exp_edge_q.push_back(edge_cnt + lane_pkg::PIPE_DEPTH - 1);
        exp_data_q.push_back(res);
        exp_name_q.push_back(test_name);
        commit_edge_q.push_back(edge_cnt + lane_pkg::PIPE_DEPTH);
        commit_rd_q.push_back(rd_i);
        commit_bwen_q.push_back(keep ? bwen_i : 4'h0);
        commit_data_q.push_back(res);
        commit_mwe_q.push_back(mask_wr_i && (op_i == lane_pkg::ALU_SEQ ||
                                             op_i == lane_pkg::ALU_SLTU));
        commit_maddr_q.push_back(mask_addr_i);
    endtask

    task automatic model_commit();
        lane_pkg::vreg_addr_t rd;
        lane_pkg::byte_en_t   be;
        lane_pkg::word_t      data;
        lane_pkg::word_t      bitmask;
        logic                 mwe;
        lane_pkg::mask_addr_t maddr;
        if (commit_edge_q.size() > 0 && commit_edge_q[0] == edge_cnt) begin
            void'(commit_edge_q.pop_front());
            rd = commit_rd_q.pop_front();
            be = commit_bwen_q.pop_front();
            data = commit_data_q.pop_front();
            mwe = commit_mwe_q.pop_front();
            maddr = commit_maddr_q.pop_front();
            bitmask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
            model_vreg[rd] = (model_vreg[rd] & ~bitmask) | (data & bitmask);
            if (mwe) begin
                model_mask[maddr] = data[0];
            end
        end
    endtask

    task automatic check_output();
        if (result_valid_o) begin
            if (exp_edge_q.size() == 0) begin
                error_cnt++;
                $display("Unexpected result_valid_o at edge %0d with nothing issued", edge_cnt);
            end else begin
                check_cnt++;
                if (exp_edge_q[0] != edge_cnt) begin
                    error_cnt++;
                    $display("[ERROR] %s latency: expected edge %0d, actual edge %0d",
                             exp_name_q[0], exp_edge_q[0], edge_cnt);
                end
                if (result_o !== exp_data_q[0]) begin
                    error_cnt++;
                    $display("[ERROR] %s: expected %h, actual %h",
                             exp_name_q[0], exp_data_q[0], result_o);
                end
                void'(exp_edge_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_name_q.pop_front());
            end
        end else if (exp_edge_q.size() > 0 && exp_edge_q[0] <= edge_cnt) begin
            error_cnt++;
            $display("Result of %s missing at edge %0d", exp_name_q[0], edge_cnt);
            void'(exp_edge_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_name_q.pop_front());
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // One clock edge, model update, then output check 1 ns later
    task automatic tick();
        @(posedge clk_i);
        edge_cnt++;
        if (issue_i) begin
            model_issue();
        end
        model_commit();
        #1;
        check_output();
    endtask

    task automatic issue_now();
        issue_i = 1'b1;
        tick();
        issue_i = 1'b0;
    endtask

    // Harmless defaults, no register or mask write
    task automatic clear_fields();
        op_i = lane_pkg::ALU_ADD;
        op2_sel_i = lane_pkg::OP2_VEC;
        sew_i = lane_pkg::SEW_32;
        ra_i = '0;
        rb_i = '0;
        el_a_i = '0;
        el_b_i = '0;
        scalar_i = '0;
        imm_i = '0;
        rd_i = '0;
        bwen_i = '0;
        vm_i = 1'b0;
        mask_addr_i = '0;
        mask_wr_i = 1'b0;
    endtask

    task automatic random_fields();
        op_i = lane_pkg::alu_op_t'($urandom % 7);
        op2_sel_i = lane_pkg::op2_sel_t'($urandom % 3);
        sew_i = lane_pkg::sew_t'($urandom % 3);
        el_a_i = lane_pkg::elem_idx_t'($urandom);
        el_b_i = lane_pkg::elem_idx_t'($urandom);
        scalar_i = $urandom;
        imm_i = lane_pkg::imm_t'($urandom);
        bwen_i = lane_pkg::byte_en_t'($urandom);
        vm_i = 1'($urandom);
        mask_addr_i = lane_pkg::mask_addr_t'($urandom);
        mask_wr_i = 1'($urandom);
    endtask

    // Register 63 is never written before the random stream, so it reads zero
    task automatic load_reg(int r, lane_pkg::word_t val, int be);
        clear_fields();
        op2_sel_i = lane_pkg::OP2_SCALAR;
        ra_i = 6'd63;
        scalar_i = val;
        rd_i = lane_pkg::vreg_addr_t'(r);
        bwen_i = lane_pkg::byte_en_t'(be);
        issue_now();
    endtask

    task automatic read_reg(int r);
        clear_fields();
        op_i = lane_pkg::ALU_OR;
        op2_sel_i = lane_pkg::OP2_IMM;
        ra_i = lane_pkg::vreg_addr_t'(r);
        issue_now();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_edge_q.size() > 0 || commit_edge_q.size() > 0) && waited < 12) begin
            tick();
            waited++;
        end
        if (exp_edge_q.size() > 0 || commit_edge_q.size() > 0) begin
            error_cnt++;
            $display("Timed out waiting for pending results in %s", test_name);
            exp_edge_q.delete();
            exp_data_q.delete();
            exp_name_q.delete();
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h2af12e51));
        rst_i = 1'b0;
        issue_i = 1'b0;
        clear_fields();
        edge_cnt = 0;
        error_cnt = 0;
        check_cnt = 0;
        gate_addr = '0;
        test_name = "reset";
        for (int i = 0; i < lane_pkg::VREG_DEPTH; i++) begin
            model_vreg[i] = '0;
        end
        for (int i = 0; i < lane_pkg::MASK_DEPTH; i++) begin
            model_mask[i] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        // Quiet output, then every register reads zero
        test_name = "zero_read";
        repeat (4) tick();
        for (int r = 0; r < lane_pkg::VREG_DEPTH; r++) begin
            read_reg(r);
        end
        drain();

        test_name = "load";
        for (int r = 0; r < 48; r++) begin
            load_reg(r, $urandom, 15);
        end
        drain();

        test_name = "alu_ops";
        for (int op = 0; op < 7; op++) begin
            for (int sel = 0; sel < 3; sel++) begin
                repeat (4) begin
                    random_fields();
                    op_i = lane_pkg::alu_op_t'(op);
                    op2_sel_i = lane_pkg::op2_sel_t'(sel);
                    ra_i = lane_pkg::vreg_addr_t'($urandom % 48);
                    rb_i = lane_pkg::vreg_addr_t'($urandom % 48);
                    rd_i = lane_pkg::vreg_addr_t'(48 + $urandom % 8);
                    vm_i = 1'b0;
                    mask_wr_i = 1'b0;
                    issue_now();
                end
            end
        end
        drain();

        // Operand a through ADD with zero, operand b through OR with zero
        test_name = "extract";
        for (int sew = 0; sew < 3; sew++) begin
            for (int el = 0; el < 4; el++) begin
                clear_fields();
                sew_i = lane_pkg::sew_t'(sew);
                op2_sel_i = lane_pkg::OP2_IMM;
                ra_i = lane_pkg::vreg_addr_t'($urandom % 48);
                el_a_i = lane_pkg::elem_idx_t'(el);
                issue_now();
                op_i = lane_pkg::ALU_OR;
                op2_sel_i = lane_pkg::OP2_VEC;
                ra_i = 6'd63;
                rb_i = lane_pkg::vreg_addr_t'($urandom % 48);
                el_b_i = lane_pkg::elem_idx_t'(el);
                issue_now();
            end
        end
        drain();

        test_name = "byte_enable";
        for (int k = 0; k < 16; k++) begin
            load_reg(60, $urandom, 15);
            drain();
            load_reg(60, $urandom, k);
            drain();
            read_reg(60);
            drain();
        end

        // Compare into a mask bit, then a masked write gated by it
        test_name = "mask_gate";
        load_reg(61, 32'h1234_5678, 15);
        drain();
        repeat (24) begin
            gate_addr = lane_pkg::mask_addr_t'($urandom % 8);
            clear_fields();
            op_i = lane_pkg::ALU_SEQ;
            op2_sel_i = lane_pkg::OP2_SCALAR;
            ra_i = 6'd61;
            scalar_i = ($urandom % 2 == 1) ? 32'h1234_5678 : 32'h1234_5679;
            mask_addr_i = gate_addr;
            mask_wr_i = 1'b1;
            issue_now();
            drain();
            load_reg(57, $urandom, 15);
            drain();
            // New data, so a blocked write is told apart from a done one
            scalar_i = $urandom;
            vm_i = 1'b1;
            mask_addr_i = gate_addr;
            issue_now();
            drain();
            read_reg(57);
        end
        drain();

        // Back-to-back stream over few registers so reads hit writes in flight
        test_name = "random_stream";
        for (int n = 0; n < 400; n++) begin
            random_fields();
            ra_i = lane_pkg::vreg_addr_t'($urandom % 12);
            rb_i = lane_pkg::vreg_addr_t'($urandom % 12);
            rd_i = lane_pkg::vreg_addr_t'($urandom % 8);
            mask_addr_i = lane_pkg::mask_addr_t'($urandom % 6);
            if ($urandom % 4 != 0) begin
                issue_now();
            end else begin
                tick();
            end
        end
        drain();

        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0 && check_cnt > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/lane_pkg.sv
verilog/vec_regfile.sv
verilog/mask_regfile.sv
verilog/elem_extract.sv
verilog/lane_alu.sv
verilog/issue_pipe.sv
verilog/vector_lane.sv
verification/tb_vector_lane.sv

/* run_sim.sh */
#!/bin/sh
# Build the vector lane testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_vector_lane -f vlog.f -o sim_vector_lane \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_vector_lane)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qF "TEST RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
